// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv32_int_core_tb
LOG       ?= sim.log
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
RUN_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	else \
	  echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
src/rv32_pkg.sv
src/decode_if.sv
src/execute_if.sv
src/rv32_decode.sv
src/rv32_execute.sv
src/rv32_result.sv
src/rv32_int_core.sv
tb/rv32_core_checker.sv
tb/rv32_int_core_tb.sv

// File: src/decode_if.sv
interface decode_if #(
  parameter int REG_BITS = 5
);

  // One decoded instruction, valid for a single cycle
  logic                 valid;
  rv32_pkg::alu_op_e    alu_op;
  logic                 use_imm;
  logic [11:0]          imm;
  logic [REG_BITS-1:0]  rs1;
  logic [REG_BITS-1:0]  rs2;
  logic [REG_BITS-1:0]  rd;
  logic                 illegal;

  modport decoder (
    output valid, alu_op, use_imm, imm, rs1, rs2, rd, illegal
  );

  modport executor (
    input valid, alu_op, use_imm, imm, rs1, rs2, rd, illegal
  );

endinterface

// File: src/execute_if.sv
interface execute_if #(
  parameter int REG_BITS = 5
);

  // Register file read port, answered combinationally
  logic [REG_BITS-1:0]  rs1_addr;
  logic [REG_BITS-1:0]  rs2_addr;
  rv32_pkg::word_t      rs1_data;
  rv32_pkg::word_t      rs2_data;

  // Registered result pulse toward retire
  logic                 valid;
  logic [REG_BITS-1:0]  rd;
  rv32_pkg::word_t      data;
  logic                 illegal;

  modport executor (
    output rs1_addr, rs2_addr, valid, rd, data, illegal,
    input  rs1_data, rs2_data
  );

  modport result (
    input  rs1_addr, rs2_addr, valid, rd, data, illegal,
    output rs1_data, rs2_data
  );

endinterface

// File: src/rv32_decode.sv
module rv32_decode #(
  parameter int REG_BITS = 5
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             instr_req_i,
  input  rv32_pkg::word_t  instr_i,
  output logic             instr_ack_o,
  decode_if.decoder        dec
);

  rv32_pkg::instr_u   instr;
  rv32_pkg::alu_op_e  alu_op;
  logic               accept;
  logic               alt;
  logic               use_imm;
  logic               op_bad;
  logic               reg_bad;

  // True when a 5-bit register field does not fit the file
  function automatic logic reg_out_of_range(input logic [4:0] idx);
    return (idx >> REG_BITS) != 5'd0;
  endfunction

  assign instr  = instr_i;
  assign accept = instr_req_i & ~instr_ack_o;

  //////////////////////////////////////////////////////////////
  // Four-phase handshake
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      instr_ack_o <= 1'b0;
    end else if (accept) begin
      instr_ack_o <= 1'b1;
    end else if (!instr_req_i) begin
      instr_ack_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////////////////

  // In OP-IMM only the shift-right form reads funct7 as an opcode bit
  assign alt = (instr.r.funct7 == rv32_pkg::F7_ALT) &
               ((instr.r.opcode == rv32_pkg::OPC_OP) | (instr.r.funct3 == 3'b101));

  always_comb begin
    case (instr.r.funct3)
      3'b000:  alu_op = alt ? rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
      3'b001:  alu_op = rv32_pkg::ALU_SLL;
      3'b010:  alu_op = rv32_pkg::ALU_SLT;
      3'b011:  alu_op = rv32_pkg::ALU_SLTU;
      3'b100:  alu_op = rv32_pkg::ALU_XOR;
      3'b101:  alu_op = alt ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
      3'b110:  alu_op = rv32_pkg::ALU_OR;
      default: alu_op = rv32_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    use_imm = 1'b0;
    op_bad  = 1'b0;
    reg_bad = reg_out_of_range(instr.r.rd) | reg_out_of_range(instr.r.rs1);
    case (instr.r.opcode)
      rv32_pkg::OPC_OP: begin
        reg_bad = reg_bad | reg_out_of_range(instr.r.rs2);
        if (instr.r.funct7 == rv32_pkg::F7_ALT) begin
          op_bad = (instr.r.funct3 != 3'b000) && (instr.r.funct3 != 3'b101);
        end else begin
          op_bad = instr.r.funct7 != rv32_pkg::F7_BASE;
        end
      end
      rv32_pkg::OPC_OP_IMM: begin
        use_imm = 1'b1;
        // Shift immediates keep only a 5-bit amount
        if (instr.r.funct3 == 3'b001) begin
          op_bad = instr.r.funct7 != rv32_pkg::F7_BASE;
        end else if (instr.r.funct3 == 3'b101) begin
          op_bad = (instr.r.funct7 != rv32_pkg::F7_BASE) &&
                   (instr.r.funct7 != rv32_pkg::F7_ALT);
        end
      end
      default: op_bad = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////////////////
  // Decode register, loaded on the acceptance edge
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec.alu_op  <= alu_op;
      dec.use_imm <= use_imm;
      dec.imm     <= instr.i.imm12;
      dec.rs1     <= instr.r.rs1[REG_BITS-1:0];
      dec.rs2     <= instr.r.rs2[REG_BITS-1:0];
      dec.rd      <= instr.r.rd[REG_BITS-1:0];
      dec.illegal <= op_bad | reg_bad;
    end
  end

endmodule

// File: src/rv32_execute.sv
module rv32_execute (
  input  logic        clk_i,
  input  logic        reset_i,
  decode_if.executor  dec,
  execute_if.executor exe
);

  rv32_pkg::word_t  op_a;
  rv32_pkg::word_t  op_b;
  rv32_pkg::word_t  alu_result;
  logic [4:0]       shamt;

  //////////////////////////////////////////////////////////////
  // Operand selection
  //////////////////////////////////////////////////////////////

  // Register file is read during the cycle after acceptance
  assign exe.rs1_addr = dec.rs1;
  assign exe.rs2_addr = dec.rs2;

  assign op_a = exe.rs1_data;

  // Sign-extended 12-bit immediate or second register
  assign op_b = dec.use_imm ?
                {{(rv32_pkg::XLEN-12){dec.imm[11]}}, dec.imm} :
                exe.rs2_data;

  assign shamt = op_b[4:0];

  //////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////

  always_comb begin
    case (dec.alu_op)
      rv32_pkg::ALU_ADD:  alu_result = op_a + op_b;
      rv32_pkg::ALU_SUB:  alu_result = op_a - op_b;
      rv32_pkg::ALU_SLL:  alu_result = op_a << shamt;
      rv32_pkg::ALU_SLT:  alu_result = rv32_pkg::word_t'($signed(op_a) < $signed(op_b));
      rv32_pkg::ALU_SLTU: alu_result = rv32_pkg::word_t'(op_a < op_b);
      rv32_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
      rv32_pkg::ALU_SRL:  alu_result = op_a >> shamt;
      rv32_pkg::ALU_SRA:  alu_result = rv32_pkg::word_t'($signed(op_a) >>> shamt);
      rv32_pkg::ALU_OR:   alu_result = op_a | op_b;
      rv32_pkg::ALU_AND:  alu_result = op_a & op_b;
      default:            alu_result = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////
  // Execute register
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe.valid <= 1'b0;
    end else begin
      exe.valid <= dec.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec.valid) begin
      exe.rd      <= dec.rd;
      exe.illegal <= dec.illegal;
      // Illegal instructions retire with no data
      exe.data    <= dec.illegal ? '0 : alu_result;
    end
  end

endmodule

// File: src/rv32_int_core.sv
module rv32_int_core #(
  parameter int REG_BITS = 5
) (
  input  logic                 clk_i,
  input  logic                 reset_i,

  // Four-phase instruction port
  input  logic                 instr_req_i,
  input  rv32_pkg::word_t      instr_i,
  output logic                 instr_ack_o,

  // One pulse per retired instruction
  output logic                 retire_valid_o,
  output logic                 retire_illegal_o,
  output logic [REG_BITS-1:0]  retire_rd_o,
  output rv32_pkg::word_t      retire_data_o
);

  decode_if  #(.REG_BITS(REG_BITS)) dec_if ();
  execute_if #(.REG_BITS(REG_BITS)) exe_if ();

  rv32_decode #(
    .REG_BITS    (REG_BITS)
  ) u_decode (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .instr_req_i (instr_req_i),
    .instr_i     (instr_i),
    .instr_ack_o (instr_ack_o),
    .dec         (dec_if.decoder)
  );

  rv32_execute u_execute (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .dec     (dec_if.executor),
    .exe     (exe_if.executor)
  );

  rv32_result #(
    .REG_BITS         (REG_BITS)
  ) u_result (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .exe              (exe_if.result),
    .retire_valid_o   (retire_valid_o),
    .retire_illegal_o (retire_illegal_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o)
  );

endmodule

// File: src/rv32_pkg.sv
package rv32_pkg;

  //////////////////////////////////////////////////////////////
  // Widths and base types
  //////////////////////////////////////////////////////////////

  localparam int XLEN = 32;

  // One data or instruction word
  typedef logic [XLEN-1:0] word_t;

  //////////////////////////////////////////////////////////////
  // Opcode and funct7 encodings
  //////////////////////////////////////////////////////////////

  // Register-register and register-immediate integer groups
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // Alternate funct7 selects sub and the arithmetic shift
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // ALU operations resolved in decode
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  //////////////////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  // Top 12 bits hold the immediate above the R-type low fields
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

endpackage

// File: src/rv32_result.sv
module rv32_result #(
  parameter int REG_BITS = 5
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  execute_if.result            exe,
  output logic                 retire_valid_o,
  output logic                 retire_illegal_o,
  output logic [REG_BITS-1:0]  retire_rd_o,
  output rv32_pkg::word_t      retire_data_o
);

  rv32_pkg::word_t  regs [2**REG_BITS];
  logic             wr_en;

  //////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////

  // x0 is never written, so it keeps its reset value of zero
  assign wr_en = exe.valid & ~exe.illegal & (exe.rd != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs <= '{default: '0};
    end else if (wr_en) begin
      regs[exe.rd] <= exe.data;
    end
  end

  // Combinational read ports for execute
  assign exe.rs1_data = regs[exe.rs1_addr];
  assign exe.rs2_data = regs[exe.rs2_addr];

  //////////////////////////////////////////////////////////////
  // Retire report
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      retire_valid_o   <= 1'b0;
      retire_illegal_o <= 1'b0;
      retire_rd_o      <= '0;
      retire_data_o    <= '0;
    end else begin
      retire_valid_o <= exe.valid;
      // Fields hold their last value between pulses
      if (exe.valid) begin
        retire_illegal_o <= exe.illegal;
        retire_rd_o      <= exe.rd;
        retire_data_o    <= exe.data;
      end
    end
  end

endmodule

// File: tb/rv32_core_checker.sv
module rv32_core_checker (
  input logic         clk_i,
  input logic         reset_i,
  input logic         instr_req_i,
  input logic         ack_i,
  input logic         retire_valid_i,
  input logic         retire_illegal_i,
  input logic [31:0]  retire_data_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int assert_failures = 0;

  //////////////////////////////////////////////////////////////
  // Handshake and retire protocol
  //////////////////////////////////////////////////////////////

  // Acknowledge answers a request seen on the previous edge
  ack_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ack_i) |-> $past(instr_req_i))
    else begin
      $error("instr_ack_o rose without a pending request");
      assert_failures++;
    end

  retire_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    retire_valid_i |=> !retire_valid_i)
    else begin
      $error("retire_valid_o stayed high for more than one cycle");
      assert_failures++;
    end

  illegal_zero_data: assert property (@(posedge clk_i) disable iff (reset_i)
    (retire_valid_i && retire_illegal_i) |-> (retire_data_i == '0))
    else begin
      $error("illegal retire carried nonzero data");
      assert_failures++;
    end

  quiet_after_reset: assert property (@(posedge clk_i)
    reset_i |=> (!ack_i && !retire_valid_i))
    else begin
      $error("acknowledge or retire high in the cycle after reset");
      assert_failures++;
    end

endmodule

bind rv32_int_core rv32_core_checker core_checker (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .instr_req_i      (instr_req_i),
  .ack_i            (instr_ack_o),
  .retire_valid_i   (retire_valid_o),
  .retire_illegal_i (retire_illegal_o),
  .retire_data_i    (retire_data_o)
);

// File: tb/rv32_int_core_tb.sv
module rv32_int_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int REG_BITS    = 5;
  localparam int NUM_INSTR   = 200;
  localparam int CYCLE_LIMIT = NUM_INSTR * 8 + 50;

  logic                 clk_i;
  logic                 reset_i;
  logic                 instr_req_i;
  rv32_pkg::word_t      instr_i;
  logic                 instr_ack_o;
  logic                 retire_valid_o;
  logic                 retire_illegal_o;
  logic [REG_BITS-1:0]  retire_rd_o;
  rv32_pkg::word_t      retire_data_o;

  logic [31:0]          rng_state;
  int                   cycle_count;
  int                   retire_count;
  rv32_pkg::word_t      model_regs [2**REG_BITS];

  // Expected retire fields, one entry per accepted instruction
  rv32_pkg::word_t      exp_data_q [$];
  logic                 exp_illegal_q [$];
  logic [REG_BITS-1:0]  exp_rd_q [$];
  int                   exp_cycle_q [$];

  rv32_int_core #(
    .REG_BITS         (REG_BITS)
  ) dut_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .instr_req_i      (instr_req_i),
    .instr_i          (instr_i),
    .instr_ack_o      (instr_ack_o),
    .retire_valid_o   (retire_valid_o),
    .retire_illegal_o (retire_illegal_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o)
  );

  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      abort_run("DUT output differs from the reference model");
    end
  endtask

  // ADDI xN, x0, imm to give each register a known value
  function automatic rv32_pkg::word_t seed_addi(input int reg_idx);
    logic [31:0] r;
    r = lcg_next();
    return {r[31:20], 5'd0, 3'b000, 5'(reg_idx), rv32_pkg::OPC_OP_IMM};
  endfunction

  // Roughly 45% OP, 45% OP-IMM, 10% illegal
  function automatic rv32_pkg::word_t random_instr(input int idx);
    logic [31:0]     r;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      funct3;
    logic [11:0]     imm;
    int              sel;
    rv32_pkg::word_t ins;
    r      = lcg_next();
    sel    = int'(r[31:16] % 16'd100);
    r      = lcg_next();
    rd     = r[31:27];
    rs1    = r[26:22];
    rs2    = r[21:17];
    funct3 = r[16:14];
    imm    = r[13:2];
    // Regular writes to x0
    if (idx % 16 == 0) begin
      rd = 5'd0;
    end
    if (sel < 45) begin
      ins = {rv32_pkg::F7_BASE, rs2, rs1, funct3, rd, rv32_pkg::OPC_OP};
      if ((funct3 == 3'b000 || funct3 == 3'b101) && r[1]) begin
        ins[31:25] = rv32_pkg::F7_ALT;
      end
    end else if (sel < 90) begin
      if (funct3 == 3'b001) begin
        imm[11:5] = rv32_pkg::F7_BASE;
      end else if (funct3 == 3'b101) begin
        imm[11:5] = r[1] ? rv32_pkg::F7_ALT : rv32_pkg::F7_BASE;
      end
      ins = {imm, rs1, funct3, rd, rv32_pkg::OPC_OP_IMM};
    end else begin
      r = lcg_next();
      case (r[31:30])
        2'd0:    ins = {imm, rs1, funct3, rd, 7'b0000011};
        2'd1:    ins = {imm, rs1, funct3, rd, 7'b1100011};
        // Alternate funct7 outside sub and sra
        2'd2:    ins = {rv32_pkg::F7_ALT, rs2, rs1, funct3 | 3'b010, rd, rv32_pkg::OPC_OP};
        default: ins = {7'b0000001, imm[4:0], rs1, r[29] ? 3'b001 : 3'b101, rd,
                        rv32_pkg::OPC_OP_IMM};
      endcase
    end
    return ins;
  endfunction

  //////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////

  function automatic void expected_result(input rv32_pkg::word_t ins, output logic illegal,
                                          output rv32_pkg::word_t data);
    logic [6:0]      opcode;
    logic [6:0]      funct7;
    logic [2:0]      funct3;
    logic            is_op;
    logic [4:0]      shamt;
    rv32_pkg::word_t a;
    rv32_pkg::word_t b;
    opcode = ins[6:0];
    funct3 = ins[14:12];
    funct7 = ins[31:25];
    is_op  = opcode == rv32_pkg::OPC_OP;
    a      = model_regs[ins[19:15]];
    b      = is_op ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    shamt  = b[4:0];
    if (is_op) begin
      illegal = !((funct7 == rv32_pkg::F7_BASE) ||
                  (funct7 == rv32_pkg::F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)));
    end else if (opcode == rv32_pkg::OPC_OP_IMM) begin
      illegal = (funct3 == 3'b001 && funct7 != rv32_pkg::F7_BASE) ||
                (funct3 == 3'b101 && funct7 != rv32_pkg::F7_BASE &&
                 funct7 != rv32_pkg::F7_ALT);
    end else begin
      illegal = 1'b1;
    end
    case (funct3)
      3'b000:  data = (is_op && funct7 == rv32_pkg::F7_ALT) ? a - b : a + b;
      3'b001:  data = a << shamt;
      // Differing signs decide the signed compare on their own
      3'b010:  data = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
      3'b011:  data = {31'b0, a < b};
      3'b100:  data = a ^ b;
      3'b101: begin
        data = a >> shamt;
        if (funct7 == rv32_pkg::F7_ALT && a[31]) begin
          data = data | ~(32'hffffffff >> shamt);
        end
      end
      3'b110:  data = a | b;
      default: data = a & b;
    endcase
    if (illegal) begin
      data = '0;
    end
  endfunction

  // Full four-phase handshake for one instruction
  task automatic send_instr(input rv32_pkg::word_t ins);
    logic            illegal;
    rv32_pkg::word_t data;
    instr_i     = ins;
    instr_req_i = 1'b1;
    do @(negedge clk_i); while (!instr_ack_o);
    expected_result(ins, illegal, data);
    exp_data_q.push_back(data);
    exp_illegal_q.push_back(illegal);
    exp_rd_q.push_back(ins[11:7]);
    exp_cycle_q.push_back(cycle_count);
    if (!illegal && ins[11:7] != 5'd0) begin
      model_regs[ins[11:7]] = data;
    end
    instr_req_i = 1'b0;
    do @(negedge clk_i); while (instr_ack_o);
  endtask

  //////////////////////////////////////////////////////////////
  // Compare and timeout
  //////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (dut_i.core_checker.assert_failures != 0) begin
      abort_run("Protocol checker reported an assertion failure");
    end else if (!reset_i && retire_valid_o) begin
      if (exp_data_q.size() == 0) begin
        abort_run("Retire pulse seen without a handshaken instruction");
      end else begin
        check_value($sformatf("instr %0d timing", retire_count),
                    exp_cycle_q.pop_front() + 2, cycle_count);
        check_value($sformatf("instr %0d rd", retire_count),
                    32'(exp_rd_q.pop_front()), 32'(retire_rd_o));
        check_value($sformatf("instr %0d illegal", retire_count),
                    32'(exp_illegal_q.pop_front()), 32'(retire_illegal_o));
        check_value($sformatf("instr %0d data", retire_count),
                    exp_data_q.pop_front(), retire_data_o);
        retire_count++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      abort_run("Timeout: the run exceeded its cycle limit");
    end
  end

  //////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////

  initial begin
    rv32_pkg::word_t ins;
    int              gap;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    instr_req_i  = 1'b0;
    instr_i      = '0;
    rng_state    = 32'h7c60aefc;
    cycle_count  = 0;
    retire_count = 0;
    model_regs   = '{default: '0};
    repeat (2) @(negedge clk_i);
    reset_i = 1'b0;
    for (int n = 0; n < NUM_INSTR; n++) begin
      // Registers x1 to x31 are seeded first
      ins = (n < 2**REG_BITS - 1) ? seed_addi(n + 1) : random_instr(n);
      send_instr(ins);
      gap = int'(lcg_next() >> 30);
      repeat (gap) @(negedge clk_i);
    end
    while (exp_data_q.size() != 0) @(negedge clk_i);
    // Quiet period catches stray retire pulses
    repeat (5) @(negedge clk_i);
    if (dut_i.core_checker.assert_failures == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run("Protocol checker reported an assertion failure");
    end
  end

endmodule
